// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= ifu_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build $(TOP) with Verilator, run it and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS SIM_ARGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "test: failed"; exit 1; fi
	@if ! grep -q "TB PASSED" $(LOG); then echo "test: no pass line in $(LOG)"; exit 1; fi
	@echo "test: passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/ifu_sva.sv ====
`default_nettype none

module ifu_sva
  import ifu_pkg::*;
(
  input wire logic            clk,
  input wire logic            rst,
  input wire logic [xlen-1:0] araddr_i,
  input wire logic            arvalid_i,
  input wire logic            rvalid_i,
  input wire fetch_out_t      fetch_i,
  input wire logic            valid_i,
  input wire logic            ready_i,
  input wire logic            redirect_i
);

  int unsigned fail_count = 0;
  logic        is_cf;
  logic        cf_wait_q;

  assign is_cf = fetch_i.inst[6:0] inside {op_jal, op_jalr, op_branch, op_system};

  // Set by a control-flow transfer, cleared by the redirect that answers it.
  always_ff @(posedge clk) begin
    if (rst) begin
      cf_wait_q <= 1'b0;
    end else if (redirect_i) begin
      cf_wait_q <= 1'b0;
    end else if (valid_i && ready_i && is_cf) begin
      cf_wait_q <= 1'b1;
    end
  end

  // A read keeps its level and address until the data pulse.
  addr_stable_a : assert property (
    @(posedge clk) disable iff (rst)
    arvalid_i && !rvalid_i |=> arvalid_i && $stable(araddr_i)
  ) else begin
    fail_count = fail_count + 1;
    $error("araddr_o or arvalid_o changed before rvalid_i");
  end

  req_drop_a : assert property (
    @(posedge clk) disable iff (rst)
    arvalid_i && rvalid_i |=> !arvalid_i
  ) else begin
    fail_count = fail_count + 1;
    $error("arvalid_o still high in the cycle after rvalid_i");
  end

  wait_redirect_a : assert property (
    @(posedge clk) disable iff (rst)
    cf_wait_q |-> !valid_i
  ) else begin
    fail_count = fail_count + 1;
    $error("valid_o high while waiting for a redirect");
  end

  // Back-pressure freezes the offered instruction.
  hold_a : assert property (
    @(posedge clk) disable iff (rst)
    valid_i && !ready_i |=> valid_i && $stable(fetch_i)
  ) else begin
    fail_count = fail_count + 1;
    $error("valid_o or fetch_o changed while ready_i was low");
  end

endmodule

`default_nettype wire

// ==== dv/ifu_tb.sv ====
`default_nettype none

module ifu_tb
  import ifu_pkg::*;
();

  localparam int mem_words = 256;
  localparam int n_xfers   = 3000;
  localparam int max_idle  = 200;

  logic                 clk = 1'b0;
  logic                 rst;
  logic [xlen-1:0]      araddr;
  logic                 arvalid;
  logic [xlen-1:0]      rdata;
  logic                 rvalid;
  fetch_out_t           fetch;
  logic                 valid;
  logic                 ready;
  logic                 redirect;
  logic [xlen-1:0]      npc;

  logic [xlen-1:0]      mem [mem_words];
  logic [31:0]          rng;
  logic [xlen-1:0]      exp_pc;
  logic                 exp_wait;
  logic                 m_valid [l1i_sets];
  logic [l1i_tag_w-1:0] m_tag [l1i_sets];
  int                   redir_delay;
  logic                 bus_busy;
  logic                 bus_drop;
  logic                 bus_second;
  logic [xlen-1:0]      bus_addr;
  int                   bus_delay;
  logic                 held;
  fetch_out_t           held_fetch;
  int                   xfers;
  int                   idle;

  ifu_top i_ifu_top (
    .clk        (clk),
    .rst        (rst),
    .araddr_o   (araddr),
    .arvalid_o  (arvalid),
    .rdata_i    (rdata),
    .rvalid_i   (rvalid),
    .fetch_o    (fetch),
    .valid_o    (valid),
    .ready_i    (ready),
    .redirect_i (redirect),
    .npc_i      (npc)
  );

  bind ifu_top ifu_sva i_ifu_sva (
    .clk        (clk),
    .rst        (rst),
    .araddr_i   (araddr_o),
    .arvalid_i  (arvalid_o),
    .rvalid_i   (rvalid_i),
    .fetch_i    (fetch_o),
    .valid_i    (valid_o),
    .ready_i    (ready_i),
    .redirect_i (redirect_i)
  );

  always #10 clk = ~clk;

  ////////////////////
  // Helpers
  ////////////////////

  function automatic logic [31:0] xorshift32();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  // Address split is tag[31:5], set[4:3], word[2], byte[1:0].
  function automatic logic [xlen-1:0] line_base(input logic [xlen-1:0] addr);
    return {addr[31:3], 3'b000};
  endfunction

  function automatic logic model_hit(input logic [xlen-1:0] addr);
    return m_valid[addr[4:3]] && (m_tag[addr[4:3]] == addr[31:5]);
  endfunction

  function automatic logic [xlen-1:0] mem_word(input logic [xlen-1:0] addr);
    logic [xlen-1:0] off;
    off = addr - pc_init;
    return mem[off[9:2]];
  endfunction

  function automatic logic is_ctrl_flow(input logic [xlen-1:0] inst);
    case (inst[6:0])
      7'h6f, 7'h67, 7'h63, 7'h73: return 1'b1;
      default:                    return 1'b0;
    endcase
  endfunction

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("TB FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_fetch(input string name, input fetch_out_t got, input fetch_out_t exp);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] %s got pc=%h inst=%h, expected pc=%h inst=%h",
                          name, got.pc, got.inst, exp.pc, exp.inst));
    end
  endtask

  task automatic check_addr(input string name, input logic [xlen-1:0] got,
                            input logic [xlen-1:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] %s got %h, expected %h", name, got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] %s got %h, expected %h", name, got, exp));
    end
  endtask

  task automatic fill_memory();
    logic [31:0] word;
    logic [31:0] pick;
    for (int i = 0; i < mem_words; i++) begin
      word = xorshift32();
      pick = xorshift32();
      if (pick[1:0] == 2'b00) begin
        case (pick[3:2])
          2'd0:    word[6:0] = 7'h6f;
          2'd1:    word[6:0] = 7'h67;
          2'd2:    word[6:0] = 7'h63;
          default: word[6:0] = 7'h73;
        endcase
      end else if (is_ctrl_flow(word)) begin
        word[6:0] = 7'h33;
      end
      mem[i] = word;
    end
    // The run opens with an ordinary word and FENCE.I; a jump closes the memory.
    mem[0][6:0]           = 7'h13;
    mem[1]                = inst_fence_i;
    mem[mem_words-1][6:0] = 7'h6f;
  endtask

  ////////////////////
  // One cycle
  ////////////////////

  // Runs at the falling edge, where all DUT outputs are settled.
  task automatic step_cycle();
    fetch_out_t exp_f;
    logic       exp_valid;
    logic [1:0] idx;

    if (i_ifu_top.i_ifu_sva.fail_count != 0) begin
      abort_run("a bound assertion on the ifu_top interfaces failed");
    end
    exp_valid = !exp_wait && model_hit(exp_pc);
    check_flag("valid_o", valid, exp_valid);
    if (held) begin
      check_fetch("fetch_o", fetch, held_fetch);
    end

    // Memory responder.
    rvalid = 1'b0;
    rdata  = '0;
    if (bus_drop) begin
      check_flag("arvalid_o", arvalid, 1'b0);
      bus_drop = 1'b0;
    end else if (arvalid) begin
      if (!bus_busy) begin
        if (!bus_second && (exp_wait || model_hit(exp_pc))) begin
          abort_run("bus read issued for a line that the model holds");
        end
        check_addr("araddr_o", araddr, line_base(exp_pc) | (bus_second ? 32'h4 : 32'h0));
        bus_busy  = 1'b1;
        bus_addr  = araddr;
        bus_delay = 1 + int'(xorshift32() % 5);
      end
      bus_delay--;
      if (bus_delay == 0) begin
        rvalid   = 1'b1;
        rdata    = mem_word(bus_addr);
        bus_busy = 1'b0;
        bus_drop = 1'b1;
        if (bus_second) begin
          idx          = exp_pc[4:3];
          m_valid[idx] = 1'b1;
          m_tag[idx]   = exp_pc[31:5];
        end
        bus_second = !bus_second;
      end
    end else if (bus_busy) begin
      abort_run("arvalid_o dropped before the read data returned");
    end

    redirect = 1'b0;
    if (exp_wait) begin
      if (redir_delay == 0) begin
        npc      = pc_init + ((xorshift32() % mem_words) << 2);
        redirect = 1'b1;
        exp_pc   = npc;
        exp_wait = 1'b0;
      end else begin
        redir_delay--;
      end
    end

    // Decode side.
    ready = (xorshift32() % 4) != 0;
    if (valid && ready) begin
      exp_f.pc   = exp_pc;
      exp_f.inst = mem_word(exp_pc);
      check_fetch("fetch_o", fetch, exp_f);
      xfers++;
      idle = 0;
      if (is_ctrl_flow(exp_f.inst)) begin
        exp_wait    = 1'b1;
        redir_delay = int'(xorshift32() % 4);
      end else begin
        if (exp_f.inst == inst_fence_i) begin
          for (int s = 0; s < l1i_sets; s++) begin
            m_valid[s] = 1'b0;
          end
        end
        exp_pc = exp_pc + 4;
      end
    end else begin
      idle++;
      if (idle > max_idle) begin
        abort_run($sformatf("no instruction delivered for %0d cycles", max_idle));
      end
    end
    held       = valid && !ready;
    held_fetch = fetch;
  endtask

  initial begin
    rst         = 1'b1;
    ready       = 1'b0;
    rvalid      = 1'b0;
    rdata       = '0;
    redirect    = 1'b0;
    npc         = '0;
    rng         = 32'd85;
    fill_memory();
    exp_pc      = pc_init;
    exp_wait    = 1'b0;
    redir_delay = 0;
    bus_busy    = 1'b0;
    bus_drop    = 1'b0;
    bus_second  = 1'b0;
    bus_addr    = '0;
    bus_delay   = 0;
    held        = 1'b0;
    held_fetch  = '0;
    xfers       = 0;
    idle        = 0;
    for (int s = 0; s < l1i_sets; s++) begin
      m_valid[s] = 1'b0;
      m_tag[s]   = '0;
    end
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    while (xfers < n_xfers) begin
      step_cycle();
      @(negedge clk);
    end
    $display("%0d transfers checked", xfers);
    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== rtl/ifu_pc_ctrl.sv ====
`default_nettype none

module ifu_pc_ctrl
  import ifu_pkg::*;
(
  input  wire logic            clk,
  input  wire logic            rst,
  input  wire logic            hit_i,
  input  wire logic [xlen-1:0] inst_i,
  input  wire logic            ready_i,
  input  wire logic            redirect_i,
  input  wire logic [xlen-1:0] npc_i,
  output logic      [xlen-1:0] pc_o,
  output logic                 valid_o,
  output fetch_out_t           fetch_o,
  output logic                 flush_o
);

  fetch_state_e    state_q;
  logic [xlen-1:0] pc_q;
  opcode_e         opcode;
  logic            is_cf;
  logic            is_fence_i;
  logic            xfer;

  ////////////////////
  // Decode
  ////////////////////

  assign opcode = opcode_e'(inst_i[6:0]);

  // Anything that may change the flow waits for decode to send the target.
  always_comb begin
    case (opcode)
      op_jal, op_jalr, op_branch, op_system: is_cf = 1'b1;
      default:                               is_cf = 1'b0;
    endcase
  end

  assign is_fence_i = (opcode == op_misc_mem) && (inst_i == inst_fence_i);

  ////////////////////
  // Delivery
  ////////////////////

  assign valid_o = hit_i && (state_q == fs_fetch);
  assign xfer    = valid_o && ready_i;

  assign fetch_o.pc   = pc_q;
  assign fetch_o.inst = inst_i;

  // Sets clear at the transfer edge so the next pc already misses.
  assign flush_o = xfer && is_fence_i;

  ////////////////////
  // PC and state
  ////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= fs_fetch;
      pc_q    <= pc_init;
    end else begin
      case (state_q)
        fs_fetch: begin
          if (xfer) begin
            if (is_cf) begin
              state_q <= fs_wait_redirect;
            end else begin
              pc_q <= pc_q + xlen'(4);
            end
          end
        end
        fs_wait_redirect: begin
          if (redirect_i) begin
            state_q <= fs_fetch;
            pc_q    <= npc_i;
          end
        end
        default: state_q <= fs_fetch;
      endcase
    end
  end

  assign pc_o = pc_q;

endmodule

`default_nettype wire

// ==== rtl/ifu_pkg.sv ====
`default_nettype none

package ifu_pkg;

  ////////////////////
  // Sizes
  ////////////////////

  localparam int xlen = 32;

  // Direct-mapped L1I with 4 sets and two words per line.
  localparam int l1i_sets  = 4;
  localparam int l1i_idx_w = 2;
  localparam int l1i_off_w = 1;
  localparam int l1i_tag_w = 27;

  // Bit positions of the address fields.
  localparam int l1i_byte_w  = 2;
  localparam int l1i_idx_lsb = l1i_byte_w + l1i_off_w;
  localparam int l1i_tag_lsb = l1i_idx_lsb + l1i_idx_w;

  localparam logic [xlen-1:0] pc_init = 32'h8000_0000;

  // fence.i with rd = rs1 = 0 and imm = 0.
  localparam logic [xlen-1:0] inst_fence_i = 32'h0000_100f;

  ////////////////////
  // Encodings
  ////////////////////

  typedef enum logic [6:0] {
    op_jal      = 7'b110_1111,
    op_jalr     = 7'b110_0111,
    op_branch   = 7'b110_0011,
    op_system   = 7'b111_0011,
    op_misc_mem = 7'b000_1111,
    op_other    = 7'b000_0000
  } opcode_e;

  typedef enum logic [1:0] {
    rf_idle,
    rf_word0,
    rf_word1
  } refill_state_e;

  typedef enum logic {
    fs_fetch,
    fs_wait_redirect
  } fetch_state_e;

  ////////////////////
  // Cache structs
  ////////////////////

  typedef struct packed {
    logic                 valid;
    logic [l1i_tag_w-1:0] tag;
    logic [xlen-1:0]      word0;
    logic [xlen-1:0]      word1;
  } l1i_line_t;

  typedef struct packed {
    logic [l1i_idx_w-1:0] idx;
    logic [l1i_tag_w-1:0] tag;
    logic [xlen-1:0]      word0;
    logic [xlen-1:0]      word1;
  } l1i_fill_t;

  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [xlen-1:0] inst;
  } fetch_out_t;

endpackage

`default_nettype wire

// ==== rtl/ifu_top.sv ====
`default_nettype none

module ifu_top
  import ifu_pkg::*;
(
  input  wire logic            clk,
  input  wire logic            rst,
  output logic      [xlen-1:0] araddr_o,
  output logic                 arvalid_o,
  input  wire logic [xlen-1:0] rdata_i,
  input  wire logic            rvalid_i,
  output fetch_out_t           fetch_o,
  output logic                 valid_o,
  input  wire logic            ready_i,
  input  wire logic            redirect_i,
  input  wire logic [xlen-1:0] npc_i
);

  logic [xlen-1:0] pc;
  logic            hit;
  logic [xlen-1:0] inst;
  logic            flush;
  l1i_fill_t       fill;
  logic            fill_we;
  l1i_line_t       lines [l1i_sets];

  ifu_pc_ctrl i_pc_ctrl (
    .clk        (clk),
    .rst        (rst),
    .hit_i      (hit),
    .inst_i     (inst),
    .ready_i    (ready_i),
    .redirect_i (redirect_i),
    .npc_i      (npc_i),
    .pc_o       (pc),
    .valid_o    (valid_o),
    .fetch_o    (fetch_o),
    .flush_o    (flush)
  );

  l1i_refill i_refill (
    .clk       (clk),
    .rst       (rst),
    .pc_i      (pc),
    .hit_i     (hit),
    .araddr_o  (araddr_o),
    .arvalid_o (arvalid_o),
    .rdata_i   (rdata_i),
    .rvalid_i  (rvalid_i),
    .fill_o    (fill),
    .fill_we_o (fill_we)
  );

  for (genvar i = 0; i < l1i_sets; i++) begin : g_set
    l1i_set #(
      .set_idx (i)
    ) i_set (
      .clk       (clk),
      .rst       (rst),
      .flush_i   (flush),
      .fill_i    (fill),
      .fill_we_i (fill_we),
      .line_o    (lines[i])
    );
  end

  l1i_hit_sel i_hit_sel (
    .pc_i    (pc),
    .lines_i (lines),
    .hit_o   (hit),
    .inst_o  (inst)
  );

endmodule

`default_nettype wire

// ==== rtl/l1i_hit_sel.sv ====
`default_nettype none

module l1i_hit_sel
  import ifu_pkg::*;
(
  input  wire logic [xlen-1:0] pc_i,
  input  wire l1i_line_t       lines_i [l1i_sets],
  output logic                 hit_o,
  output logic      [xlen-1:0] inst_o
);

  logic [l1i_idx_w-1:0] idx;
  logic [l1i_off_w-1:0] off;
  logic [l1i_tag_w-1:0] tag;
  l1i_line_t            line;

  assign idx = pc_i[l1i_idx_lsb +: l1i_idx_w];
  assign off = pc_i[l1i_byte_w +: l1i_off_w];
  assign tag = pc_i[l1i_tag_lsb +: l1i_tag_w];

  assign line = lines_i[idx];

  assign hit_o = line.valid && (line.tag == tag);

  // Odd words sit in word1.
  always_comb begin
    if (off != '0) begin
      inst_o = line.word1;
    end else begin
      inst_o = line.word0;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/l1i_refill.sv ====
`default_nettype none

module l1i_refill
  import ifu_pkg::*;
(
  input  wire logic            clk,
  input  wire logic            rst,
  input  wire logic [xlen-1:0] pc_i,
  input  wire logic            hit_i,
  output logic      [xlen-1:0] araddr_o,
  output logic                 arvalid_o,
  input  wire logic [xlen-1:0] rdata_i,
  input  wire logic            rvalid_i,
  output l1i_fill_t            fill_o,
  output logic                 fill_we_o
);

  refill_state_e   state_q;
  logic            req_q;
  logic [xlen-1:0] addr_q;
  logic [xlen-1:0] word0_q;
  logic [xlen-1:0] line_base;

  assign line_base = {pc_i[xlen-1:l1i_idx_lsb], {l1i_idx_lsb{1'b0}}};

  ////////////////////
  // Refill FSM
  ////////////////////

  // Each read is a level request that drops for one cycle after its data pulse.
  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= rf_idle;
      req_q   <= 1'b0;
    end else begin
      case (state_q)
        rf_idle: begin
          if (!hit_i) begin
            state_q <= rf_word0;
            req_q   <= 1'b1;
          end
        end
        rf_word0: begin
          if (rvalid_i) begin
            state_q <= rf_word1;
            req_q   <= 1'b0;
          end
        end
        rf_word1: begin
          if (rvalid_i) begin
            state_q <= rf_idle;
            req_q   <= 1'b0;
          end else begin
            req_q <= 1'b1;
          end
        end
        default: begin
          state_q <= rf_idle;
          req_q   <= 1'b0;
        end
      endcase
    end
  end

  // Request address and the buffered even word.
  always_ff @(posedge clk) begin
    if (state_q == rf_idle && !hit_i) begin
      addr_q <= line_base;
    end
    if (state_q == rf_word0 && rvalid_i) begin
      addr_q  <= line_base | xlen'(4);
      word0_q <= rdata_i;
    end
  end

  assign araddr_o  = addr_q;
  assign arvalid_o = req_q;

  // The odd word goes straight into the set with the second pulse.
  assign fill_we_o    = (state_q == rf_word1) && rvalid_i;
  assign fill_o.idx   = pc_i[l1i_idx_lsb +: l1i_idx_w];
  assign fill_o.tag   = pc_i[l1i_tag_lsb +: l1i_tag_w];
  assign fill_o.word0 = word0_q;
  assign fill_o.word1 = rdata_i;

endmodule

`default_nettype wire

// ==== rtl/l1i_set.sv ====
`default_nettype none

module l1i_set
  import ifu_pkg::*;
#(
  parameter int set_idx = 0
) (
  input  wire logic      clk,
  input  wire logic      rst,
  input  wire logic      flush_i,
  input  wire l1i_fill_t fill_i,
  input  wire logic      fill_we_i,
  output l1i_line_t      line_o
);

  logic                 valid_q;
  logic [l1i_tag_w-1:0] tag_q;
  logic [xlen-1:0]      word0_q;
  logic [xlen-1:0]      word1_q;
  logic                 sel;

  // Only the set addressed by the refill takes the write.
  assign sel = fill_we_i && (fill_i.idx == l1i_idx_w'(set_idx));

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;
    end else if (sel) begin
      valid_q <= 1'b1;
    end
  end

  // Line payload.
  always_ff @(posedge clk) begin
    if (sel) begin
      tag_q   <= fill_i.tag;
      word0_q <= fill_i.word0;
      word1_q <= fill_i.word1;
    end
  end

  assign line_o.valid = valid_q;
  assign line_o.tag   = tag_q;
  assign line_o.word0 = word0_q;
  assign line_o.word1 = word1_q;

endmodule

`default_nettype wire

// ==== vlog.f ====
rtl/ifu_pkg.sv
rtl/l1i_set.sv
rtl/l1i_refill.sv
rtl/l1i_hit_sel.sv
rtl/ifu_pc_ctrl.sv
rtl/ifu_top.sv
dv/ifu_sva.sv
dv/ifu_tb.sv
